// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_cpu16
FILELIST := cpu16.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu16.f ====
+incdir+.
source/cpu16_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/id_ex_reg.sv
source/exec_unit.sv
source/cpu16_core.sv
dv/cpu16_checker.sv
dv/tb_cpu16.sv

// ==== cpu16_defines.svh ====
`ifndef CPU16_DEFINES_SVH
`define CPU16_DEFINES_SVH

// datapath widths
`define CPU16_DATA_W 16
`define CPU16_PC_W   16

// general register file
`define CPU16_REG_N  8
`define CPU16_REG_AW 3

// opcode field in inst[15:11]
`define CPU16_OP_NOP   5'd0
`define CPU16_OP_ADDU  5'd1
`define CPU16_OP_SUBU  5'd2
`define CPU16_OP_AND   5'd3
`define CPU16_OP_OR    5'd4
`define CPU16_OP_SLT   5'd5
`define CPU16_OP_ADDIU 5'd6
`define CPU16_OP_LI    5'd7
`define CPU16_OP_SLL   5'd8
`define CPU16_OP_BEQZ  5'd9
`define CPU16_OP_B     5'd10

`endif

// ==== dv/cpu16_checker.sv ====
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module cpu16_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          inst,
    input  cpu16_pkg::pc_t       inst_pc,
    input  logic                 inst_valid,
    input  logic [127:0]         test_name,
    input  logic                 res_we,
    input  cpu16_pkg::reg_addr_t res_addr,
    input  cpu16_pkg::data_t     res_data,
    input  logic                 branch_taken,
    input  cpu16_pkg::pc_t       branch_target,
    output int                   errors,
    output int                   pending
);

    localparam int NAME_W      = 128;
    localparam int LATENCY_MAX = 16;

    // architectural state updated in program order
    cpu16_pkg::data_t     model_regs [`CPU16_REG_N];
    logic                 squash_next;
    int                   cycle;

    // expected strobes with the oldest at the front
    logic                 exp_branch [$];
    cpu16_pkg::reg_addr_t exp_addr   [$];
    cpu16_pkg::data_t     exp_val    [$];
    logic [NAME_W-1:0]    exp_name   [$];
    int                   exp_cycle  [$];

    logic                 want_branch;
    cpu16_pkg::reg_addr_t want_addr;
    cpu16_pkg::data_t     want_val;
    logic [NAME_W-1:0]    want_name;

    function automatic string name_text(input logic [NAME_W-1:0] raw);
        string s;
        s = "";
        for (int i = NAME_W / 8 - 1; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, raw[i*8 +: 8]);
            end
        end
        return s;
    endfunction

    task automatic push_event(input logic branch, input cpu16_pkg::reg_addr_t addr,
                              input cpu16_pkg::data_t val);
        exp_branch.push_back(branch);
        exp_addr.push_back(addr);
        exp_val.push_back(val);
        exp_name.push_back(test_name);
        exp_cycle.push_back(cycle);
    endtask

    task automatic drop_front();
        want_branch = exp_branch.pop_front();
        want_addr   = exp_addr.pop_front();
        want_val    = exp_val.pop_front();
        want_name   = exp_name.pop_front();
        void'(exp_cycle.pop_front());
    endtask

    task automatic expect_write(input cpu16_pkg::reg_addr_t addr, input cpu16_pkg::data_t val);
        model_regs[addr] = val;
        push_event(1'b0, addr, val);
    endtask

    task automatic expect_branch(input cpu16_pkg::pc_t target);
        squash_next = 1'b1;
        push_event(1'b1, '0, target);
    endtask

    task automatic model_step();
        logic [4:0]       op;
        cpu16_pkg::data_t a;
        cpu16_pkg::data_t b;
        cpu16_pkg::data_t s8;
        op = inst[15:11];
        a  = model_regs[inst[10:8]];
        b  = model_regs[inst[7:5]];
        s8 = {{8{inst[7]}}, inst[7:0]};
        if (squash_next) begin
            // slot behind a taken branch
            squash_next = 1'b0;
        end else begin
            case (op)
                `CPU16_OP_ADDU:  expect_write(inst[4:2], a + b);
                `CPU16_OP_SUBU:  expect_write(inst[4:2], a - b);
                `CPU16_OP_AND:   expect_write(inst[4:2], a & b);
                `CPU16_OP_OR:    expect_write(inst[4:2], a | b);
                `CPU16_OP_SLT:   expect_write(inst[4:2], ($signed(a) < $signed(b)) ? 16'd1 : 16'd0);
                `CPU16_OP_ADDIU: expect_write(inst[10:8], a + s8);
                `CPU16_OP_LI:    expect_write(inst[10:8], {8'h00, inst[7:0]});
                `CPU16_OP_SLL:   expect_write(inst[10:8], b << inst[4:2]);
                `CPU16_OP_BEQZ: begin
                    if (a == 16'd0) begin
                        expect_branch(inst_pc + 16'd1 + s8);
                    end
                end
                `CPU16_OP_B:     expect_branch(inst_pc + 16'd1 + {{5{inst[10]}}, inst[10:0]});
                default: ;
            endcase
        end
    endtask

    task automatic compare_strobe();
        if (res_we && branch_taken) begin
            $display("ERROR: write and branch strobes are high in the same cycle");
            errors = errors + 1;
        end else if (exp_branch.size() == 0) begin
            $display("ERROR: %s strobe seen while no instruction was outstanding",
                     branch_taken ? "branch" : "write");
            errors = errors + 1;
        end else begin
            drop_front();
            if (want_branch != branch_taken) begin
                $display("ERROR: %s gave a %s strobe where a %s strobe was due",
                         name_text(want_name), branch_taken ? "branch" : "write",
                         want_branch ? "branch" : "write");
                errors = errors + 1;
            end else if (branch_taken) begin
                if (branch_target != want_val) begin
                    $display("FAILED %s branch_target: expected %h, actual %h",
                             name_text(want_name), want_val, branch_target);
                    errors = errors + 1;
                end
            end else begin
                if (res_addr != want_addr) begin
                    $display("FAILED %s res_addr: expected %0d, actual %0d",
                             name_text(want_name), want_addr, res_addr);
                    errors = errors + 1;
                end
                if (res_data != want_val) begin
                    $display("FAILED %s res_data: expected %h, actual %h",
                             name_text(want_name), want_val, res_data);
                    errors = errors + 1;
                end
            end
        end
    endtask

    task automatic check_age();
        if (exp_branch.size() > 0 && (cycle - exp_cycle[0]) > LATENCY_MAX) begin
            $display("ERROR: %s produced no strobe within %0d cycles",
                     name_text(exp_name[0]), LATENCY_MAX);
            errors = errors + 1;
            drop_front();
        end
    endtask

    // inputs and outputs are both read as they stood before the edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU16_REG_N; i++) begin
                model_regs[i] = '0;
            end
            squash_next = 1'b0;
            cycle       = 0;
            errors      = 0;
            exp_branch.delete();
            exp_addr.delete();
            exp_val.delete();
            exp_name.delete();
            exp_cycle.delete();
        end else begin
            cycle = cycle + 1;
            if (res_we || branch_taken) begin
                compare_strobe();
            end
            check_age();
            if (inst_valid) begin
                model_step();
            end
        end
        pending = exp_branch.size();
    end

endmodule

// ==== dv/tb_cpu16.sv ====
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module tb_cpu16;

    localparam int NAME_W      = 128;
    localparam int DRAIN_LIMIT = 40;

    logic                 clk;
    logic                 rst;
    logic [15:0]          inst;
    cpu16_pkg::pc_t       inst_pc;
    logic                 inst_valid;
    logic                 pause;
    logic                 res_we;
    cpu16_pkg::reg_addr_t res_addr;
    cpu16_pkg::data_t     res_data;
    logic                 branch_taken;
    cpu16_pkg::pc_t       branch_target;
    logic [NAME_W-1:0]    test_name;
    int                   chk_errors;
    int                   chk_pending;
    int                   tb_errors;
    int                   seed;

    // a negative gap in the stimulus table asks for a random pause length
    logic [15:0]          tbl_inst [$];
    cpu16_pkg::pc_t       tbl_pc   [$];
    int                   tbl_gap  [$];
    logic [NAME_W-1:0]    tbl_name [$];

    always #2 clk = ~clk;

    cpu16_core i_dut (
        .clk           (clk),
        .rst           (rst),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_valid    (inst_valid),
        .pause         (pause),
        .res_we        (res_we),
        .res_addr      (res_addr),
        .res_data      (res_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    cpu16_checker i_checker (
        .clk           (clk),
        .rst           (rst),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .inst_valid    (inst_valid),
        .test_name     (test_name),
        .res_we        (res_we),
        .res_addr      (res_addr),
        .res_data      (res_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .errors        (chk_errors),
        .pending       (chk_pending)
    );

    function automatic logic [15:0] r_fmt(input logic [4:0] op, input int x, input int y,
                                          input int z);
        return {op, 3'(x), 3'(y), 3'(z), 2'b00};
    endfunction

    function automatic logic [15:0] i_fmt(input logic [4:0] op, input int x,
                                          input logic [7:0] imm);
        return {op, 3'(x), imm};
    endfunction

    function automatic logic [15:0] j_fmt(input logic [4:0] op, input logic [10:0] imm);
        return {op, imm};
    endfunction

    task automatic add_step(input logic [15:0] word, input cpu16_pkg::pc_t pc, input int gap,
                            input logic [NAME_W-1:0] name);
        tbl_inst.push_back(word);
        tbl_pc.push_back(pc);
        tbl_gap.push_back(gap);
        tbl_name.push_back(name);
    endtask

    task automatic build_table();
        add_step(i_fmt(`CPU16_OP_LI, 1, 8'h25), 16'h0010, 0, "li_r1");
        add_step(i_fmt(`CPU16_OP_LI, 2, 8'hF3), 16'h0011, 0, "li_zext");
        add_step(r_fmt(`CPU16_OP_ADDU, 1, 2, 3), 16'h0012, 0, "addu_dist1_2");
        add_step(r_fmt(`CPU16_OP_SUBU, 3, 1, 4), 16'h0013, 0, "subu_fwd");
        add_step(r_fmt(`CPU16_OP_AND, 3, 2, 5), 16'h0014, 0, "and_rz");
        add_step(r_fmt(`CPU16_OP_OR, 1, 4, 6), 16'h0015, 0, "or_rz");
        add_step(r_fmt(`CPU16_OP_SLT, 1, 2, 7), 16'h0016, 0, "slt_pos");
        add_step(i_fmt(`CPU16_OP_ADDIU, 1, 8'hF0), 16'h0017, 0, "addiu_neg");
        add_step(i_fmt(`CPU16_OP_ADDIU, 0, 8'hFF), 16'h0018, 1, "addiu_m1_r0");
        add_step(r_fmt(`CPU16_OP_SLT, 0, 1, 5), 16'h0019, 0, "slt_neg");
        add_step(r_fmt(`CPU16_OP_SLL, 6, 2, 3), 16'h001A, 0, "sll_3");
        add_step(r_fmt(`CPU16_OP_SLL, 7, 6, 7), 16'h001B, 0, "sll_7_fwd");
        add_step(16'h0000, 16'h001C, -1, "nop");
        add_step(r_fmt(5'd31, 1, 2, 3), 16'h001D, 0, "unknown_op");
        add_step(r_fmt(`CPU16_OP_ADDU, 7, 3, 2), 16'h001E, -1, "addu_after_pause");
        add_step(i_fmt(`CPU16_OP_BEQZ, 1, 8'h05), 16'h001F, 0, "beqz_not_taken");
        add_step(i_fmt(`CPU16_OP_LI, 4, 8'h00), 16'h0020, 0, "li_zero");
        add_step(i_fmt(`CPU16_OP_BEQZ, 4, 8'h10), 16'h0021, 0, "beqz_taken");
        add_step(i_fmt(`CPU16_OP_LI, 5, 8'h77), 16'h0022, 0, "squash_beqz");
        add_step(r_fmt(`CPU16_OP_OR, 5, 4, 3), 16'h0032, 0, "after_beqz");
        add_step(j_fmt(`CPU16_OP_B, 11'h7F8), 16'h0033, -1, "b_back");
        add_step(i_fmt(`CPU16_OP_LI, 1, 8'h99), 16'h0034, 0, "squash_b");
        add_step(i_fmt(`CPU16_OP_ADDIU, 1, 8'h01), 16'h002C, 0, "after_b");
        add_step(r_fmt(`CPU16_OP_SUBU, 2, 2, 6), 16'h002D, -1, "subu_zero");
        add_step(i_fmt(`CPU16_OP_BEQZ, 6, 8'hFC), 16'h002E, -1, "beqz_back");
        add_step(i_fmt(`CPU16_OP_LI, 7, 8'h55), 16'h002F, -1, "squash_gap");
        add_step(r_fmt(`CPU16_OP_ADDU, 6, 7, 0), 16'h002B, -1, "after_beqz_back");
        add_step(r_fmt(`CPU16_OP_ADDU, 0, 1, 2), 16'h002C, 2, "addu_last");
    endtask

    // pause cycles first, then a one-cycle strobe
    task automatic apply_step(input int idx);
        int gap;
        gap = tbl_gap[idx];
        if (gap < 0) begin
            gap = $unsigned($random(seed)) % 6;
        end
        for (int c = 0; c < gap; c++) begin
            @(posedge clk);
            inst_valid <= 1'b0;
            pause      <= 1'b1;
        end
        @(posedge clk);
        pause      <= 1'b0;
        inst       <= tbl_inst[idx];
        inst_pc    <= tbl_pc[idx];
        test_name  <= tbl_name[idx];
        inst_valid <= 1'b1;
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        @(negedge clk);
        while (chk_pending != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (chk_pending != 0) begin
            $display("ERROR: timeout while draining, %0d expected strobes never came",
                     chk_pending);
            tb_errors++;
        end
        // quiet window for stray strobes
        repeat (4) @(negedge clk);
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        inst       = '0;
        inst_pc    = '0;
        inst_valid = 1'b0;
        pause      = 1'b0;
        test_name  = '0;
        tb_errors  = 0;
        seed       = 32'h2c86;
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < tbl_inst.size(); i++) begin
            apply_step(i);
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        drain_outputs();
        $display("tb_cpu16: %0d errors (checker %0d, testbench %0d)",
                 tb_errors + chk_errors, chk_errors, tb_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== source/cpu16_core.sv ====
`timescale 1ns/1ps

module cpu16_core (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          inst,
    input  cpu16_pkg::pc_t       inst_pc,
    input  logic                 inst_valid,
    input  logic                 pause,
    output logic                 res_we,
    output cpu16_pkg::reg_addr_t res_addr,
    output cpu16_pkg::data_t     res_data,
    output logic                 branch_taken,
    output cpu16_pkg::pc_t       branch_target
);

    // decode stage
    cpu16_pkg::reg_addr_t  d_ra_addr;
    cpu16_pkg::reg_addr_t  d_rb_addr;
    cpu16_pkg::reg_addr_t  d_wb_addr;
    cpu16_pkg::alu_op_t    d_alu_op;
    cpu16_pkg::alu_b_sel_t d_b_sel;
    cpu16_pkg::jump_t      d_jump;
    logic                  d_wb_en;
    logic                  d_valid;
    cpu16_pkg::data_t      d_imm;
    cpu16_pkg::data_t      d_shamt;
    cpu16_pkg::data_t      d_ra_data;
    cpu16_pkg::data_t      d_rb_data;

    // execute stage
    cpu16_pkg::reg_addr_t  e_ra_addr;
    cpu16_pkg::reg_addr_t  e_rb_addr;
    cpu16_pkg::reg_addr_t  e_wb_addr;
    cpu16_pkg::alu_op_t    e_alu_op;
    cpu16_pkg::alu_b_sel_t e_b_sel;
    cpu16_pkg::jump_t      e_jump;
    logic                  e_wb_en;
    logic                  e_valid;
    cpu16_pkg::data_t      e_imm;
    cpu16_pkg::data_t      e_shamt;
    cpu16_pkg::data_t      e_ra_data;
    cpu16_pkg::data_t      e_rb_data;
    cpu16_pkg::pc_t        e_pc;
    logic                  flush;

    inst_decode i_decode (
        .inst       (inst),
        .inst_valid (inst_valid),
        .ra_addr    (d_ra_addr),
        .rb_addr    (d_rb_addr),
        .wb_addr    (d_wb_addr),
        .alu_op     (d_alu_op),
        .b_sel      (d_b_sel),
        .jump       (d_jump),
        .wb_en      (d_wb_en),
        .valid      (d_valid),
        .imm        (d_imm),
        .shamt      (d_shamt)
    );

    // written back straight from the execute result register
    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .ra_addr (d_ra_addr),
        .rb_addr (d_rb_addr),
        .we      (res_we),
        .wa      (res_addr),
        .wd      (res_data),
        .ra_data (d_ra_data),
        .rb_data (d_rb_data)
    );

    id_ex_reg i_id_ex (
        .clk        (clk),
        .rst        (rst),
        .pause      (pause),
        .flush      (flush),
        .n_ra_addr  (d_ra_addr),
        .n_rb_addr  (d_rb_addr),
        .n_wb_addr  (d_wb_addr),
        .n_alu_op   (d_alu_op),
        .n_b_sel    (d_b_sel),
        .n_jump     (d_jump),
        .n_wb_en    (d_wb_en),
        .n_valid    (d_valid),
        .n_imm      (d_imm),
        .n_shamt    (d_shamt),
        .n_ra_data  (d_ra_data),
        .n_rb_data  (d_rb_data),
        .n_pc       (inst_pc),
        .ex_ra_addr (e_ra_addr),
        .ex_rb_addr (e_rb_addr),
        .ex_wb_addr (e_wb_addr),
        .ex_alu_op  (e_alu_op),
        .ex_b_sel   (e_b_sel),
        .ex_jump    (e_jump),
        .ex_wb_en   (e_wb_en),
        .ex_valid   (e_valid),
        .ex_imm     (e_imm),
        .ex_shamt   (e_shamt),
        .ex_ra_data (e_ra_data),
        .ex_rb_data (e_rb_data),
        .ex_pc      (e_pc)
    );

    exec_unit i_exec (
        .clk           (clk),
        .rst           (rst),
        .pause         (pause),
        .ex_ra_addr    (e_ra_addr),
        .ex_rb_addr    (e_rb_addr),
        .ex_wb_addr    (e_wb_addr),
        .ex_alu_op     (e_alu_op),
        .ex_b_sel      (e_b_sel),
        .ex_jump       (e_jump),
        .ex_wb_en      (e_wb_en),
        .ex_valid      (e_valid),
        .ex_imm        (e_imm),
        .ex_shamt      (e_shamt),
        .ex_ra_data    (e_ra_data),
        .ex_rb_data    (e_rb_data),
        .ex_pc         (e_pc),
        .flush         (flush),
        .res_we        (res_we),
        .res_addr      (res_addr),
        .res_data      (res_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// ==== source/cpu16_pkg.sv ====
`include "cpu16_defines.svh"

package cpu16_pkg;

    typedef logic [`CPU16_DATA_W-1:0] data_t;
    typedef logic [`CPU16_PC_W-1:0]   pc_t;
    typedef logic [`CPU16_REG_AW-1:0] reg_addr_t;

    // alu function for the execute stage
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_SLL,
        ALU_PASS_B
    } alu_op_t;

    // source of alu operand b
    typedef enum logic [1:0] {
        B_REG,
        B_IMM,
        B_SHAMT
    } alu_b_sel_t;

    // branch kind
    typedef enum logic [1:0] {
        JUMP_NONE,
        JUMP_BEQZ,
        JUMP_ALWAYS
    } jump_t;

endpackage

// ==== source/exec_unit.sv ====
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module exec_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pause,
    input  cpu16_pkg::reg_addr_t  ex_ra_addr,
    input  cpu16_pkg::reg_addr_t  ex_rb_addr,
    input  cpu16_pkg::reg_addr_t  ex_wb_addr,
    input  cpu16_pkg::alu_op_t    ex_alu_op,
    input  cpu16_pkg::alu_b_sel_t ex_b_sel,
    input  cpu16_pkg::jump_t      ex_jump,
    input  logic                  ex_wb_en,
    input  logic                  ex_valid,
    input  cpu16_pkg::data_t      ex_imm,
    input  cpu16_pkg::data_t      ex_shamt,
    input  cpu16_pkg::data_t      ex_ra_data,
    input  cpu16_pkg::data_t      ex_rb_data,
    input  cpu16_pkg::pc_t        ex_pc,
    output logic                  flush,
    output logic                  res_we,
    output cpu16_pkg::reg_addr_t  res_addr,
    output cpu16_pkg::data_t      res_data,
    output logic                  branch_taken,
    output cpu16_pkg::pc_t        branch_target
);

    logic             fwd_valid;
    cpu16_pkg::data_t op_a;
    cpu16_pkg::data_t reg_b;
    cpu16_pkg::data_t op_b;
    cpu16_pkg::data_t alu_res;
    logic             taken;
    logic             slt;

    // res_addr/res_data double as the forwarding register
    assign op_a  = (fwd_valid && (res_addr == ex_ra_addr)) ? res_data : ex_ra_data;
    assign reg_b = (fwd_valid && (res_addr == ex_rb_addr)) ? res_data : ex_rb_data;

    assign op_b = (ex_b_sel == cpu16_pkg::B_IMM)   ? ex_imm   :
                  (ex_b_sel == cpu16_pkg::B_SHAMT) ? ex_shamt : reg_b;

    assign slt = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_alu_op)
            cpu16_pkg::ALU_ADD:    alu_res = op_a + op_b;
            cpu16_pkg::ALU_SUB:    alu_res = op_a - op_b;
            cpu16_pkg::ALU_AND:    alu_res = op_a & op_b;
            cpu16_pkg::ALU_OR:     alu_res = op_a | op_b;
            cpu16_pkg::ALU_SLT:    alu_res = {{(`CPU16_DATA_W-1){1'b0}}, slt};
            cpu16_pkg::ALU_SLL:    alu_res = op_a << op_b;
            cpu16_pkg::ALU_PASS_B: alu_res = op_b;
            default:               alu_res = '0;
        endcase
    end

    assign taken = (ex_jump == cpu16_pkg::JUMP_ALWAYS) ||
                   ((ex_jump == cpu16_pkg::JUMP_BEQZ) && (op_a == '0));
    assign flush = ex_valid && taken;

    // strobes drop during pause, the forwarding valid holds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_we       <= 1'b0;
            branch_taken <= 1'b0;
            fwd_valid    <= 1'b0;
        end else begin
            res_we       <= !pause && ex_valid && ex_wb_en;
            branch_taken <= !pause && ex_valid && taken;
            if (!pause) begin
                fwd_valid <= ex_valid && ex_wb_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pause) begin
            res_addr      <= ex_wb_addr;
            res_data      <= alu_res;
            branch_target <= ex_pc + cpu16_pkg::pc_t'(1) + ex_imm;
        end
    end

    a_one_event: assert property (
        @(posedge clk) disable iff (rst) !(res_we && branch_taken)
    );

endmodule

// ==== source/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pause,
    input  logic                  flush,
    input  cpu16_pkg::reg_addr_t  n_ra_addr,
    input  cpu16_pkg::reg_addr_t  n_rb_addr,
    input  cpu16_pkg::reg_addr_t  n_wb_addr,
    input  cpu16_pkg::alu_op_t    n_alu_op,
    input  cpu16_pkg::alu_b_sel_t n_b_sel,
    input  cpu16_pkg::jump_t      n_jump,
    input  logic                  n_wb_en,
    input  logic                  n_valid,
    input  cpu16_pkg::data_t      n_imm,
    input  cpu16_pkg::data_t      n_shamt,
    input  cpu16_pkg::data_t      n_ra_data,
    input  cpu16_pkg::data_t      n_rb_data,
    input  cpu16_pkg::pc_t        n_pc,
    output cpu16_pkg::reg_addr_t  ex_ra_addr,
    output cpu16_pkg::reg_addr_t  ex_rb_addr,
    output cpu16_pkg::reg_addr_t  ex_wb_addr,
    output cpu16_pkg::alu_op_t    ex_alu_op,
    output cpu16_pkg::alu_b_sel_t ex_b_sel,
    output cpu16_pkg::jump_t      ex_jump,
    output logic                  ex_wb_en,
    output logic                  ex_valid,
    output cpu16_pkg::data_t      ex_imm,
    output cpu16_pkg::data_t      ex_shamt,
    output cpu16_pkg::data_t      ex_ra_data,
    output cpu16_pkg::data_t      ex_rb_data,
    output cpu16_pkg::pc_t        ex_pc
);

    // a taken branch in execute turns this slot into a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_wb_en <= 1'b0;
            ex_jump  <= cpu16_pkg::JUMP_NONE;
        end else if (!pause) begin
            ex_valid <= n_valid && !flush;
            ex_wb_en <= n_wb_en;
            ex_jump  <= n_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (!pause) begin
            ex_ra_addr <= n_ra_addr;
            ex_rb_addr <= n_rb_addr;
            ex_wb_addr <= n_wb_addr;
            ex_alu_op  <= n_alu_op;
            ex_b_sel   <= n_b_sel;
            ex_imm     <= n_imm;
            ex_shamt   <= n_shamt;
            ex_ra_data <= n_ra_data;
            ex_rb_data <= n_rb_data;
            ex_pc      <= n_pc;
        end
    end

    // an instruction offered during pause would be lost
    a_no_strobe_in_pause: assert property (
        @(posedge clk) disable iff (rst) pause |-> !n_valid
    );

endmodule

// ==== source/inst_decode.sv ====
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module inst_decode (
    input  logic [15:0]            inst,
    input  logic                   inst_valid,
    output cpu16_pkg::reg_addr_t   ra_addr,
    output cpu16_pkg::reg_addr_t   rb_addr,
    output cpu16_pkg::reg_addr_t   wb_addr,
    output cpu16_pkg::alu_op_t     alu_op,
    output cpu16_pkg::alu_b_sel_t  b_sel,
    output cpu16_pkg::jump_t       jump,
    output logic                   wb_en,
    output logic                   valid,
    output cpu16_pkg::data_t       imm,
    output cpu16_pkg::data_t       shamt
);

    logic [4:0]           opcode;
    cpu16_pkg::reg_addr_t rx;
    cpu16_pkg::reg_addr_t ry;
    cpu16_pkg::reg_addr_t rz;
    cpu16_pkg::data_t     imm8_s;
    cpu16_pkg::data_t     imm8_z;
    cpu16_pkg::data_t     imm11_s;

    assign opcode = inst[15:11];
    assign rx     = inst[10:8];
    assign ry     = inst[7:5];
    assign rz     = inst[4:2];

    // extended immediates
    assign imm8_s  = {{(`CPU16_DATA_W-8){inst[7]}}, inst[7:0]};
    assign imm8_z  = {{(`CPU16_DATA_W-8){1'b0}}, inst[7:0]};
    assign imm11_s = {{(`CPU16_DATA_W-11){inst[10]}}, inst[10:0]};
    assign shamt   = {{(`CPU16_DATA_W-3){1'b0}}, inst[4:2]};

    // nop and unknown opcodes still flow down as valid, they just do nothing
    assign valid = inst_valid;

    always_comb begin
        ra_addr = rx;
        rb_addr = ry;
        wb_addr = rz;
        alu_op  = cpu16_pkg::ALU_ADD;
        b_sel   = cpu16_pkg::B_REG;
        jump    = cpu16_pkg::JUMP_NONE;
        wb_en   = 1'b0;
        imm     = imm8_s;
        case (opcode)
            `CPU16_OP_ADDU: begin
                wb_en = 1'b1;
            end
            `CPU16_OP_SUBU: begin
                alu_op = cpu16_pkg::ALU_SUB;
                wb_en  = 1'b1;
            end
            `CPU16_OP_AND: begin
                alu_op = cpu16_pkg::ALU_AND;
                wb_en  = 1'b1;
            end
            `CPU16_OP_OR: begin
                alu_op = cpu16_pkg::ALU_OR;
                wb_en  = 1'b1;
            end
            `CPU16_OP_SLT: begin
                alu_op = cpu16_pkg::ALU_SLT;
                wb_en  = 1'b1;
            end
            `CPU16_OP_ADDIU: begin
                wb_addr = rx;
                b_sel   = cpu16_pkg::B_IMM;
                wb_en   = 1'b1;
            end
            `CPU16_OP_LI: begin
                wb_addr = rx;
                alu_op  = cpu16_pkg::ALU_PASS_B;
                b_sel   = cpu16_pkg::B_IMM;
                imm     = imm8_z;
                wb_en   = 1'b1;
            end
            `CPU16_OP_SLL: begin
                // source is ry, result goes to rx
                ra_addr = ry;
                wb_addr = rx;
                alu_op  = cpu16_pkg::ALU_SLL;
                b_sel   = cpu16_pkg::B_SHAMT;
                wb_en   = 1'b1;
            end
            `CPU16_OP_BEQZ: begin
                jump = cpu16_pkg::JUMP_BEQZ;
            end
            `CPU16_OP_B: begin
                jump = cpu16_pkg::JUMP_ALWAYS;
                imm  = imm11_s;
            end
            default: begin
                wb_en = 1'b0;
            end
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu16_defines.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  cpu16_pkg::reg_addr_t ra_addr,
    input  cpu16_pkg::reg_addr_t rb_addr,
    input  logic                 we,
    input  cpu16_pkg::reg_addr_t wa,
    input  cpu16_pkg::data_t     wd,
    output cpu16_pkg::data_t     ra_data,
    output cpu16_pkg::data_t     rb_data
);

    cpu16_pkg::data_t regs [`CPU16_REG_N];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU16_REG_N; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // a write on this edge is also the edge that id_ex captures on,
    // so hand the new value straight to the reader
    always_comb begin
        if (we && (wa == ra_addr)) begin
            ra_data = wd;
        end else begin
            ra_data = regs[ra_addr];
        end
    end

    always_comb begin
        if (we && (wa == rb_addr)) begin
            rb_data = wd;
        end else begin
            rb_data = regs[rb_addr];
        end
    end

endmodule
